//--- vlog.f
+incdir+include
source/chan_sum_pkg.sv
source/chan_sum_ctrl_if.sv
source/chan_sum_ctrl.sv
source/pixel_delay_line.sv
source/channel_adder_tree.sv
source/chan_sum_top.sv
verif/chan_sum_tb.sv

//--- Bender.yml
package:
  name: chan_sum

export_include_dirs:
  - include

sources:
  - files:
      - source/chan_sum_pkg.sv
      - source/chan_sum_ctrl_if.sv
      - source/chan_sum_ctrl.sv
      - source/pixel_delay_line.sv
      - source/channel_adder_tree.sv
      - source/chan_sum_top.sv
  - target: simulation
    files:
      - verif/chan_sum_tb.sv

//--- verif/chan_sum_tb.sv
`default_nettype none

`include "chan_sum_settings.svh"

module chan_sum_tb;
  import chan_sum_pkg::*;

  localparam int CHANNELS   = `CHAN_SUM_CHANNELS;
  localparam int MAP_PIXELS = `CHAN_SUM_MAP_PIXELS;
  localparam int FRAME_LEN  = CHANNELS * MAP_PIXELS;
  localparam int NUM_ROWS   = 6;
  // Accepting edge to the edge that samples sum_valid high
  localparam int LATENCY    = $clog2(CHANNELS) + 2;

  logic                                clk;
  logic                                reset;
  pixel_t                              pixel_in;
  logic                                pixel_valid;
  sum_t                                sum_out;
  logic                                sum_valid;
  logic [`CHAN_SUM_AXI_ADDR_WIDTH-1:0] s_awaddr;
  logic                                s_awvalid;
  logic                                s_awready;
  logic [31:0]                         s_wdata;
  logic [3:0]                          s_wstrb;
  logic                                s_wvalid;
  logic                                s_wready;
  axi_resp_t                           s_bresp;
  logic                                s_bvalid;
  logic                                s_bready;
  logic [`CHAN_SUM_AXI_ADDR_WIDTH-1:0] s_araddr;
  logic                                s_arvalid;
  logic                                s_arready;
  logic [31:0]                         s_rdata;
  axi_resp_t                           s_rresp;
  logic                                s_rvalid;
  logic                                s_rready;

  // Test table, one entry per row
  string row_name   [NUM_ROWS];
  int    row_bias   [NUM_ROWS];
  bit    row_enable [NUM_ROWS];
  int    row_frames [NUM_ROWS];
  bit    row_gaps   [NUM_ROWS];

  pixel_t      frame_px [CHANNELS][MAP_PIXELS];
  logic [31:0] exp_sums [$];
  int          exp_cycles [$];
  logic [31:0] rng_state = 32'h5b21e733;
  bit          enabled;
  int          gap_slot;
  int          cycle;
  int          cycle_limit;
  int          checks;
  int          errors;

  chan_sum_top chan_sum_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      $display("timeout after %0d cycles, results still outstanding", cycle);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic set_row(input int idx, input string name, input int bias,
                         input bit en, input int frames, input bit gaps);
    row_name[idx]   = name;
    row_bias[idx]   = bias;
    row_enable[idx] = en;
    row_frames[idx] = frames;
    row_gaps[idx]   = gaps;
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite master

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge clk);
    s_awaddr  = addr;
    s_awvalid = 1'b1;
    s_wdata   = data;
    s_wstrb   = 4'hF;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    @(negedge clk);
    while (!(s_awready && s_wready)) @(negedge clk);
    // Handshake happens on the edge after ready is seen
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    while (!s_bvalid) @(negedge clk);
    resp = s_bresp;
    @(negedge clk);
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    @(negedge clk);
    while (!s_arready) @(negedge clk);
    @(negedge clk);
    s_arvalid = 1'b0;
    while (!s_rvalid) @(negedge clk);
    data = s_rdata;
    resp = s_rresp;
    @(negedge clk);
    s_rready = 1'b0;
  endtask

  task automatic set_enable(input bit en);
    logic [1:0] resp;
    axi_write(REG_CTRL, {31'b0, en}, resp);
    check_value("s_bresp", 32'(resp), 32'(OKAY));
    enabled = en;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pixel stream and reference model

  // Fresh random frame, expected sums queued only when it will be accepted
  task automatic make_frame(input int bias);
    int total;
    for (int c = 0; c < CHANNELS; c++) begin
      for (int p = 0; p < MAP_PIXELS; p++) begin
        frame_px[c][p] = pixel_t'(next_random());
      end
    end
    if (enabled) begin
      for (int p = 0; p < MAP_PIXELS; p++) begin
        total = bias;
        for (int c = 0; c < CHANNELS; c++) begin
          total += int'(frame_px[c][p]);
        end
        exp_sums.push_back(total);
      end
    end
  endtask

  task automatic drive_pixels(input int first, input int last, input bit gaps);
    int c;
    int p;
    for (int i = first; i < last; i++) begin
      @(negedge clk);
      // Every third slot is a dropout with junk on the data
      while (gaps && (gap_slot % 3 == 2)) begin
        pixel_valid = 1'b0;
        pixel_in    = pixel_t'(next_random());
        gap_slot++;
        @(negedge clk);
      end
      gap_slot++;
      c = i / MAP_PIXELS;
      p = i % MAP_PIXELS;
      pixel_valid = 1'b1;
      pixel_in    = frame_px[c][p];
      // Accepted on edge cycle+1, sum_valid set one edge before it is sampled
      if (enabled && c == CHANNELS - 1) begin
        exp_cycles.push_back(cycle + LATENCY);
      end
    end
  endtask

  task automatic wait_results();
    while (exp_sums.size() != 0) @(negedge clk);
    // Idle tail catches any stray result
    repeat (10) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int checks_before,
                             input int errors_before);
    $display("test %-16s %0d checks, %0d errors", name, checks - checks_before,
             errors - errors_before);
  endtask

  // Results are sampled away from the rising edge
  always @(negedge clk) begin
    if (!reset && sum_valid) begin
      if (exp_sums.size() == 0) begin
        $display("unexpected result %h on sum_out with none pending", sum_out);
        errors++;
      end else begin
        check_value("sum_out", 32'(sum_out), exp_sums.pop_front());
        check_value("sum_valid cycle", cycle, exp_cycles.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [31:0] rd;
    logic [1:0]  resp;
    int          fc_before;
    int          checks_before;
    int          errors_before;

    reset       = 1'b1;
    pixel_in    = '0;
    pixel_valid = 1'b0;
    s_awaddr    = '0;
    s_awvalid   = 1'b0;
    s_wdata     = '0;
    s_wstrb     = '0;
    s_wvalid    = 1'b0;
    s_bready    = 1'b0;
    s_araddr    = '0;
    s_arvalid   = 1'b0;
    s_rready    = 1'b0;
    enabled     = 1'b0;
    gap_slot    = 0;
    cycle       = 0;
    checks      = 0;
    errors      = 0;

    set_row(0, "single_frame", 0, 1'b1, 1, 1'b0);
    set_row(1, "negative_bias", -4321, 1'b1, 1, 1'b0);
    set_row(2, "dropouts", 777, 1'b1, 2, 1'b1);
    set_row(3, "back_to_back", 100000, 1'b1, 3, 1'b0);
    set_row(4, "disabled", 55, 1'b0, 1, 1'b0);
    set_row(5, "reenabled", -200000, 1'b1, 1, 1'b1);

    // Three cycles per pixel at most, plus the split frame of the register test
    cycle_limit = 200 + 5 + FRAME_LEN * 3;
    for (int t = 0; t < NUM_ROWS; t++) begin
      cycle_limit += row_frames[t] * FRAME_LEN * 3;
    end

    repeat (5) @(negedge clk);
    reset = 1'b0;

    for (int t = 0; t < NUM_ROWS; t++) begin
      checks_before = checks;
      errors_before = errors;
      axi_read(REG_FRAME_COUNT, rd, resp);
      fc_before = rd;
      axi_write(REG_BIAS, 32'(row_bias[t]), resp);
      check_value("s_bresp", 32'(resp), 32'(OKAY));
      axi_read(REG_BIAS, rd, resp);
      check_value("s_rdata", rd, 32'(row_bias[t]));
      check_value("s_rresp", 32'(resp), 32'(OKAY));
      set_enable(row_enable[t]);
      for (int f = 0; f < row_frames[t]; f++) begin
        make_frame(row_bias[t]);
        drive_pixels(0, FRAME_LEN, row_gaps[t]);
      end
      @(negedge clk);
      pixel_valid = 1'b0;
      wait_results();
      axi_read(REG_FRAME_COUNT, rd, resp);
      check_value("frame_count", rd, fc_before + (row_enable[t] ? row_frames[t] : 0));
      report_test(row_name[t], checks_before, errors_before);
    end

    // Busy flag across a split frame, then error responses
    checks_before = checks;
    errors_before = errors;
    set_enable(1'b1);
    axi_write(REG_BIAS, 32'(-3), resp);
    check_value("s_bresp", 32'(resp), 32'(OKAY));
    axi_read(REG_STATUS, rd, resp);
    check_value("status", rd, 32'h0);
    make_frame(-3);
    drive_pixels(0, 5 * MAP_PIXELS + 3, 1'b0);
    @(negedge clk);
    pixel_valid = 1'b0;
    axi_read(REG_STATUS, rd, resp);
    check_value("status", rd, 32'h1);
    drive_pixels(5 * MAP_PIXELS + 3, FRAME_LEN, 1'b0);
    @(negedge clk);
    pixel_valid = 1'b0;
    wait_results();
    axi_read(REG_STATUS, rd, resp);
    check_value("status", rd, 32'h0);

    axi_write(4'h6, 32'h1234, resp);
    check_value("s_bresp", 32'(resp), 32'(SLVERR));
    axi_read(4'hF, rd, resp);
    check_value("s_rresp", 32'(resp), 32'(SLVERR));
    axi_write(4'h1, 32'h0, resp);
    check_value("s_bresp", 32'(resp), 32'(SLVERR));
    axi_read(REG_CTRL, rd, resp);
    check_value("ctrl", rd, 32'h1);

    axi_read(REG_FRAME_COUNT, rd, resp);
    fc_before = rd;
    axi_write(REG_FRAME_COUNT, 32'h0, resp);
    check_value("s_bresp", 32'(resp), 32'(SLVERR));
    axi_write(REG_STATUS, 32'h1, resp);
    check_value("s_bresp", 32'(resp), 32'(SLVERR));
    axi_read(REG_FRAME_COUNT, rd, resp);
    check_value("frame_count", rd, fc_before);
    report_test("register_access", checks_before, errors_before);

    if (exp_sums.size() != 0) begin
      $display("%0d expected results never arrived", exp_sums.size());
      errors++;
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/chan_sum_top.sv
`default_nettype none

`include "chan_sum_settings.svh"

module chan_sum_top (
  input  logic                                clk,
  input  logic                                reset,
  input  chan_sum_pkg::pixel_t                pixel_in,
  input  logic                                pixel_valid,
  output chan_sum_pkg::sum_t                  sum_out,
  output logic                                sum_valid,
  input  logic [`CHAN_SUM_AXI_ADDR_WIDTH-1:0] s_awaddr,
  input  logic                                s_awvalid,
  output logic                                s_awready,
  input  logic [31:0]                         s_wdata,
  input  logic [3:0]                          s_wstrb,
  input  logic                                s_wvalid,
  output logic                                s_wready,
  output chan_sum_pkg::axi_resp_t             s_bresp,
  output logic                                s_bvalid,
  input  logic                                s_bready,
  input  logic [`CHAN_SUM_AXI_ADDR_WIDTH-1:0] s_araddr,
  input  logic                                s_arvalid,
  output logic                                s_arready,
  output logic [31:0]                         s_rdata,
  output chan_sum_pkg::axi_resp_t             s_rresp,
  output logic                                s_rvalid,
  input  logic                                s_rready
);
  import chan_sum_pkg::*;

  // Tap k holds the pixel from k channels before the current one
  pixel_t taps [`CHAN_SUM_CHANNELS];

  chan_sum_ctrl_if ctrl_if ();

  chan_sum_ctrl ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .pixel_in    (pixel_in),
    .pixel_valid (pixel_valid),
    .s_awaddr    (s_awaddr),
    .s_awvalid   (s_awvalid),
    .s_awready   (s_awready),
    .s_wdata     (s_wdata),
    .s_wstrb     (s_wstrb),
    .s_wvalid    (s_wvalid),
    .s_wready    (s_wready),
    .s_bresp     (s_bresp),
    .s_bvalid    (s_bvalid),
    .s_bready    (s_bready),
    .s_araddr    (s_araddr),
    .s_arvalid   (s_arvalid),
    .s_arready   (s_arready),
    .s_rdata     (s_rdata),
    .s_rresp     (s_rresp),
    .s_rvalid    (s_rvalid),
    .s_rready    (s_rready),
    .ctrl        (ctrl_if.ctrl)
  );

  assign taps[0] = ctrl_if.pixel;

  for (genvar k = 1; k < `CHAN_SUM_CHANNELS; k++) begin : g_delay
    pixel_delay_line #(
      .DEPTH (`CHAN_SUM_MAP_PIXELS)
    ) delay_i (
      .clk       (clk),
      .reset     (reset),
      .pixel_in  (taps[k-1]),
      .shift_en  (ctrl_if.shift_en),
      .pixel_out (taps[k])
    );
  end

  channel_adder_tree tree_i (
    .clk       (clk),
    .reset     (reset),
    .taps      (taps),
    .tree      (ctrl_if.tree),
    .sum_out   (sum_out),
    .sum_valid (sum_valid)
  );

endmodule

`default_nettype wire

//--- source/channel_adder_tree.sv
`default_nettype none

`include "chan_sum_settings.svh"

module channel_adder_tree (
  input  logic                 clk,
  input  logic                 reset,
  input  chan_sum_pkg::pixel_t taps [`CHAN_SUM_CHANNELS],
  chan_sum_ctrl_if.tree        tree,
  output chan_sum_pkg::sum_t   sum_out,
  output logic                 sum_valid
);
  import chan_sum_pkg::*;

  localparam int CHANNELS = `CHAN_SUM_CHANNELS;
  localparam int LEVELS   = $clog2(CHANNELS);
  // A longer run of results would mean two frames overlapping
  localparam int MAX_RUN  = `CHAN_SUM_MAP_PIXELS + 1;

  // Heap order, root at 0 and leaves at the top end
  sum_t              node [2*CHANNELS-1];
  logic [LEVELS-1:0] valid_q;

  //////////////////////////////////////////////////////////////////////
  // Leaves and registered add levels

  for (genvar c = 0; c < CHANNELS; c++) begin : g_leaf
    assign node[CHANNELS-1+c] = sum_t'(taps[c]);
  end

  for (genvar l = 1; l <= LEVELS; l++) begin : g_level
    // Each level is one bit wider than the one below
    localparam int W     = DATA_WIDTH + l;
    localparam int FIRST = (CHANNELS >> l) - 1;

    for (genvar n = 0; n < (CHANNELS >> l); n++) begin : g_node
      logic signed [W-1:0] sum_q;

      always_ff @(posedge clk) begin
        sum_q <= W'(node[2*(FIRST+n)+1]) + W'(node[2*(FIRST+n)+2]);
      end

      assign node[FIRST+n] = sum_t'(sum_q);
    end
  end

  // Valid follows the data through the add levels
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= tree.align;
      for (int s = 1; s < LEVELS; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bias stage

  always_ff @(posedge clk) begin
    sum_out <= node[0] + tree.bias;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= valid_q[LEVELS-1];
    end
  end

  a_result_run: assert property (
    @(posedge clk) disable iff (reset) not (sum_valid [*MAX_RUN]));

endmodule

`default_nettype wire

//--- source/pixel_delay_line.sv
`default_nettype none

module pixel_delay_line #(
  parameter int DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  chan_sum_pkg::pixel_t pixel_in,
  input  logic                 shift_en,
  output chan_sum_pkg::pixel_t pixel_out
);
  import chan_sum_pkg::*;

  pixel_t line_q [DEPTH];

  // Advances per accepted pixel, so idle cycles leave the offset intact
  always_ff @(posedge clk) begin
    if (shift_en) begin
      line_q[0] <= pixel_in;
      for (int i = 1; i < DEPTH; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  // Oldest entry, one channel map behind the input
  assign pixel_out = line_q[DEPTH-1];

  a_shift_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(shift_en));

endmodule

`default_nettype wire

//--- source/chan_sum_ctrl.sv
`default_nettype none

`include "chan_sum_settings.svh"

module chan_sum_ctrl (
  input  logic                                clk,
  input  logic                                reset,
  input  chan_sum_pkg::pixel_t                pixel_in,
  input  logic                                pixel_valid,
  input  logic [`CHAN_SUM_AXI_ADDR_WIDTH-1:0] s_awaddr,
  input  logic                                s_awvalid,
  output logic                                s_awready,
  input  logic [31:0]                         s_wdata,
  input  logic [3:0]                          s_wstrb,
  input  logic                                s_wvalid,
  output logic                                s_wready,
  output chan_sum_pkg::axi_resp_t             s_bresp,
  output logic                                s_bvalid,
  input  logic                                s_bready,
  input  logic [`CHAN_SUM_AXI_ADDR_WIDTH-1:0] s_araddr,
  input  logic                                s_arvalid,
  output logic                                s_arready,
  output logic [31:0]                         s_rdata,
  output chan_sum_pkg::axi_resp_t             s_rresp,
  output logic                                s_rvalid,
  input  logic                                s_rready,
  chan_sum_ctrl_if.ctrl                       ctrl
);
  import chan_sum_pkg::*;

  localparam int CHANNELS   = `CHAN_SUM_CHANNELS;
  localparam int MAP_PIXELS = `CHAN_SUM_MAP_PIXELS;
  localparam int PIX_W      = $clog2(MAP_PIXELS);
  localparam int CHAN_W     = $clog2(CHANNELS);
  localparam logic [PIX_W-1:0]  LAST_PIX  = PIX_W'(MAP_PIXELS - 1);
  localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(CHANNELS - 1);

  logic              enable_q;
  bias_t             bias_q;
  logic [31:0]       frame_count_q;
  logic [PIX_W-1:0]  pix_cnt_q;
  logic [CHAN_W-1:0] chan_cnt_q;
  logic              accept;
  logic              last_pix;
  logic              last_chan;
  logic              busy;
  logic              wr_start;
  logic              wr_hs;
  logic              rd_start;
  logic              rd_hs;
  axi_resp_t         wr_resp;
  axi_resp_t         rd_resp;
  logic [31:0]       rd_word;

  // Byte-enable merge for partial register writes
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Pixel intake and frame position

  assign accept    = pixel_valid && enable_q;
  assign last_pix  = (pix_cnt_q == LAST_PIX);
  assign last_chan = (chan_cnt_q == LAST_CHAN);
  assign busy      = (pix_cnt_q != '0) || (chan_cnt_q != '0);

  always_ff @(posedge clk) begin
    if (accept) begin
      ctrl.pixel <= pixel_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl.shift_en <= 1'b0;
      ctrl.align    <= 1'b0;
    end else begin
      ctrl.shift_en <= accept;
      ctrl.align    <= accept && last_chan;
    end
  end

  // Disabling drops any partial frame
  always_ff @(posedge clk) begin
    if (reset || !enable_q) begin
      pix_cnt_q  <= '0;
      chan_cnt_q <= '0;
    end else if (accept) begin
      pix_cnt_q <= last_pix ? '0 : pix_cnt_q + 1'b1;
      if (last_pix) begin
        chan_cnt_q <= last_chan ? '0 : chan_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_count_q <= '0;
    end else if (accept && last_pix && last_chan) begin
      frame_count_q <= frame_count_q + 32'd1;
    end
  end

  assign ctrl.bias = bias_q;

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite slave

  // Address and data are taken together, one transaction at a time
  assign wr_start = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
  assign wr_hs    = s_awvalid && s_awready && s_wvalid && s_wready;
  assign rd_start = s_arvalid && !s_arready && !s_rvalid;
  assign rd_hs    = s_arvalid && s_arready;

  always_comb begin
    case (s_awaddr)
      REG_CTRL, REG_BIAS: wr_resp = OKAY;
      default:            wr_resp = SLVERR;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_resp = OKAY;
    case (s_araddr)
      REG_CTRL:        rd_word = {31'b0, enable_q};
      REG_BIAS:        rd_word = 32'(bias_q);
      REG_FRAME_COUNT: rd_word = frame_count_q;
      REG_STATUS:      rd_word = {31'b0, busy};
      default:         rd_resp = SLVERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      s_bvalid  <= 1'b0;
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
    end else begin
      s_awready <= wr_start;
      s_wready  <= wr_start;
      s_arready <= rd_start;
      if (wr_hs) begin
        s_bvalid <= 1'b1;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
      if (rd_hs) begin
        s_rvalid <= 1'b1;
      end else if (s_rready) begin
        s_rvalid <= 1'b0;
      end
    end
  end

  // Response payload holds until the master takes it
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      s_bresp <= wr_resp;
    end
    if (rd_hs) begin
      s_rdata <= rd_word;
      s_rresp <= rd_resp;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q <= 1'b0;
      bias_q   <= '0;
    end else if (wr_hs) begin
      case (s_awaddr)
        REG_CTRL: begin
          if (s_wstrb[0]) begin
            enable_q <= s_wdata[0];
          end
        end
        REG_BIAS: bias_q <= bias_t'(merge_bytes(32'(bias_q), s_wdata, s_wstrb));
        default: ;
      endcase
    end
  end

  a_align_with_shift: assert property (
    @(posedge clk) disable iff (reset) ctrl.align |-> ctrl.shift_en);

  a_bvalid_after_write: assert property (
    @(posedge clk) disable iff (reset)
    $rose(s_bvalid) |-> $past(s_awvalid && s_awready && s_wvalid && s_wready));

endmodule

`default_nettype wire

//--- source/chan_sum_ctrl_if.sv
`default_nettype none

interface chan_sum_ctrl_if;
  import chan_sum_pkg::*;

  // Pixel accepted on the previous edge
  pixel_t pixel;
  // One pulse per accepted pixel
  logic   shift_en;
  // Pixel belongs to the last channel of the frame
  logic   align;
  bias_t  bias;

  modport ctrl (
    output pixel,
    output shift_en,
    output align,
    output bias
  );

  modport delay (
    input pixel,
    input shift_en
  );

  modport tree (
    input align,
    input bias
  );

endinterface

`default_nettype wire

//--- source/chan_sum_pkg.sv
`default_nettype none

`include "chan_sum_settings.svh"

package chan_sum_pkg;

  localparam int DATA_WIDTH = `CHAN_SUM_DATA_WIDTH;
  // One extra bit on top of the tree growth leaves room for the bias
  localparam int SUM_WIDTH = DATA_WIDTH + $clog2(`CHAN_SUM_CHANNELS) + 1;
  localparam int AXI_ADDR_WIDTH = `CHAN_SUM_AXI_ADDR_WIDTH;

  typedef logic signed [DATA_WIDTH-1:0] pixel_t;
  typedef logic signed [SUM_WIDTH-1:0]  sum_t;
  typedef logic signed [SUM_WIDTH-1:0]  bias_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  // Register map
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL        = 'h0;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_BIAS        = 'h4;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_FRAME_COUNT = 'h8;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS      = 'hC;

endpackage

`default_nettype wire

//--- include/chan_sum_settings.svh
`ifndef CHAN_SUM_SETTINGS_SVH
`define CHAN_SUM_SETTINGS_SVH

// Width of one signed input pixel
`define CHAN_SUM_DATA_WIDTH 16

// Channels per frame, kept a power of two for the adder tree
`define CHAN_SUM_CHANNELS 8

// Pixels in one channel map
`define CHAN_SUM_MAP_PIXELS 16

// AXI4-Lite byte address width
`define CHAN_SUM_AXI_ADDR_WIDTH 4

`endif
